//--- verif/cpu_vectors.txt
# test <name> <word count> <write count>, then the program words in hex,
# then the expected write-backs in order as <register> <value> pairs, both in hex
# alu ops with a signed slt on a negative operand
test alu 9 8
20010005 2002fffd 00221820 00222022 00222824 00223025 0041382a 0022402a
08000008
1 00000005 2 fffffffd 3 00000002 4 00000008
5 00000005 6 fffffffd 7 00000001 8 00000000
# back-to-back dependencies, memory stage beats write-back on r1
test forward 7 6
20010001 20210002 20210004 00211020 00411822 00622025 08000006
1 00000001 1 00000003 1 00000007 2 0000000e 3 00000007 4 0000000f
# store then load, two load-use stalls
test loadstore 8 6
20011234 20020008 ac410004 8c430004 00612020 8c450000 00a43025 08000007
1 00001234 2 00000008 3 00001234 4 00002468 5 00000000 6 00002468
# beq not taken, beq taken, j over one word
test branch 14 7
20010003 20020003 20030009 20040001 20050002 10230002 20060006 10220002
20070007 20080008 0800000c 20090009 00c45020 0800000d
1 00000003 2 00000003 3 00000009 4 00000001 5 00000002 6 00000006
a 00000007
# r0 writes vanish, data memory cleared by reset
test zero 7 4
20000007 8c01000c 20020005 00420020 00021820 00232022 08000006
1 00000000 2 00000005 3 00000005 4 fffffffb

//--- sources.f
+incdir+src
src/cpuPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCpu.sv
verif/cpu_asserts.sv
verif/cpuTb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cpuTb -f sources.f -Mdir obj_dir
	./obj_dir/VcpuTb | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/cpuTb.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpuTb;
	logic                        clk;
	logic                        reset;
	logic                        loadValid;
	logic [`IMEM_ADDR_WIDTH-1:0] loadAddr;
	logic [`DATA_WIDTH-1:0]      loadWord;
	logic                        start;
	logic                        wbValid;
	logic [`REG_ADDR_WIDTH-1:0]  wbReg;
	logic [`DATA_WIDTH-1:0]      wbData;

	// one entry per test, program words and expected writes in flat queues
	string                      testName [$];
	int                         wordStart [$];
	int                         wordCount [$];
	int                         writeStart [$];
	int                         writeCount [$];
	logic [`DATA_WIDTH-1:0]     progWords [$];
	logic [`REG_ADDR_WIDTH-1:0] expRegs [$];
	logic [`DATA_WIDTH-1:0]     expVals [$];

	int seed = 51;
	int watchdogCycles = 0;
	int passCount = 0;
	int failCount = 0;

	pipelineCpu pipelineCpu_inst (.clk, .reset, .loadValid, .loadAddr, .loadWord, .start,
		.wbValid, .wbReg, .wbData);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////
	// vector file
	//////////////////////////////

	function automatic bit readVectors();
		int fd;
		int n;
		int words;
		int writes;
		logic [127:0] tok;
		logic [127:0] name;
		logic [1023:0] rest;
		logic [`DATA_WIDTH-1:0] word;
		logic [`REG_ADDR_WIDTH-1:0] regNum;
		logic [`DATA_WIDTH-1:0] val;
		fd = $fopen("verif/cpu_vectors.txt", "r");
		if (fd == 0)
			return 1'b0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				// comment, drop the rest of the line
				n = $fgets(rest, fd);
			end else if (tok == "test") begin
				n = $fscanf(fd, "%s %d %d", name, words, writes);
				testName.push_back(string'(name));
				wordStart.push_back(progWords.size());
				wordCount.push_back(words);
				writeStart.push_back(expRegs.size());
				writeCount.push_back(writes);
				repeat (words) begin
					n = $fscanf(fd, "%h", word);
					progWords.push_back(word);
				end
				repeat (writes) begin
					n = $fscanf(fd, "%h %h", regNum, val);
					expRegs.push_back(regNum);
					expVals.push_back(val);
				end
				watchdogCycles += 40 * (words + writes);
			end
		end
		$fclose(fd);
		return testName.size() > 0;
	endfunction

	// one word per strobe while fetch is idle
	task automatic loadProgram(input int first, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			loadValid = 1'b1;
			loadAddr = i[`IMEM_ADDR_WIDTH-1:0];
			loadWord = progWords[first + i];
		end
		@(posedge clk);
		#1;
		loadValid = 1'b0;
	endtask

	//////////////////////////////
	// one test
	//////////////////////////////

	task automatic runTest(input int t);
		int errors;
		int got;
		int waited;
		int limit;
		int idle;
		int k;
		errors = 0;
		got = 0;
		waited = 0;
		limit = 10 * wordCount[t] + 10;
		// old program words stay in the instruction memory
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		loadProgram(wordStart[t], wordCount[t]);
		idle = $random(seed) & 7;
		repeat (idle) @(posedge clk);
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		// write-backs in program order, sampled mid-cycle
		while (got < writeCount[t] && waited < limit) begin
			@(negedge clk);
			waited++;
			if (wbValid) begin
				k = writeStart[t] + got;
				assert (wbReg == expRegs[k]) else begin
					$display("Fail at %0t ns: wbReg expected %0d, actual %0d",
						$time, expRegs[k], wbReg);
					errors++;
				end
				assert (wbData == expVals[k]) else begin
					$display("Fail at %0t ns: wbData expected %h, actual %h",
						$time, expVals[k], wbData);
					errors++;
				end
				got++;
			end
		end
		assert (got == writeCount[t]) else begin
			$display("%s: only %0d of %0d write-backs arrived in %0d cycles",
				testName[t], got, writeCount[t], limit);
			errors++;
		end
		// program parks on a jump to itself
		repeat (20) begin
			@(negedge clk);
			assert (!wbValid) else begin
				$display("%s: unexpected extra write-back to r%0d at %0t ns",
					testName[t], wbReg, $time);
				errors++;
			end
		end
		if (errors == 0) begin
			passCount++;
			$display("test %s passed", testName[t]);
		end else begin
			failCount++;
			$display("test %s failed with %0d errors", testName[t], errors);
		end
	endtask

	initial begin
		reset = 1'b1;
		loadValid = 1'b0;
		loadAddr = '0;
		loadWord = '0;
		start = 1'b0;
		if (!readVectors()) begin
			$display("could not read any test from verif/cpu_vectors.txt");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			for (int t = 0; t < testName.size(); t++)
				runTest(t);
			$display("tests passed: %0d, tests failed: %0d", passCount, failCount);
			if (failCount == 0)
				$display("Simulation finished: PASS");
			else
				$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// budget comes from the vector file
	initial begin
		wait (watchdogCycles != 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not complete", watchdogCycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verif/cpu_asserts.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpuAsserts (
	input logic                       clk,
	input logic                       reset,
	input logic                       stall,
	input logic                       redirectValid,
	input logic                       isJ,
	input logic [`DATA_WIDTH-1:0]     idInstr,
	input logic                       wbValid,
	input logic [`REG_ADDR_WIDTH-1:0] wbReg
);
	// the bubble moves the load on, so a stall lasts one cycle
	stallOnce: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
		else $error("stall high for two cycles in a row");

	// a j redirects without waiting and the word behind it becomes a bubble
	jumpRedirect: assert property (@(posedge clk) disable iff (reset)
		isJ |=> idInstr == '0)
		else $error("j in decode did not squash the word fetched behind it");

	noRegZero: assert property (@(posedge clk) disable iff (reset) wbValid |-> wbReg != '0)
		else $error("write-back reported register zero");

endmodule

bind decodeStage cpuAsserts decodeAsserts_inst (.clk, .reset, .stall, .redirectValid, .isJ,
	.idInstr, .wbValid(1'b0), .wbReg('0));

bind pipelineCpu cpuAsserts topAsserts_inst (.clk, .reset, .stall(1'b0),
	.redirectValid(1'b0), .isJ(1'b0), .idInstr('0), .wbValid, .wbReg);

//--- src/pipelineCpu.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module pipelineCpu import cpuPkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        loadValid,
	input  logic [`IMEM_ADDR_WIDTH-1:0] loadAddr,
	input  logic [`DATA_WIDTH-1:0]      loadWord,
	input  logic                        start,
	output logic                        wbValid,
	output logic [`REG_ADDR_WIDTH-1:0]  wbReg,
	output logic [`DATA_WIDTH-1:0]      wbData
);
	// fetch and decode
	logic                       stall, redirectValid;
	logic [`DATA_WIDTH-1:0]     redirectTarget, idInstr, idPc4;
	// decode to execute
	logic                       exRegWrite, exMemToReg, exMemRead, exMemWrite, exAluSrc;
	aluOpT                      exAluOp;
	logic [`REG_ADDR_WIDTH-1:0] exRs, exRt, exDest;
	logic [`DATA_WIDTH-1:0]     exRsData, exRtData, exImm;
	// execute to memory
	logic                       memRegWrite, memMemToReg, memMemRead, memMemWrite;
	logic [`DATA_WIDTH-1:0]     memAluResult, memStoreData;
	logic [`REG_ADDR_WIDTH-1:0] memDest;
	// write-back
	logic                       wbWrite;
	logic [`REG_ADDR_WIDTH-1:0] wbRegAddr;
	logic [`DATA_WIDTH-1:0]     wbWriteData;

	fetchStage fetchStage_inst (.clk, .reset, .loadValid, .loadAddr, .loadWord, .start,
		.stall, .redirectValid, .redirectTarget, .idInstr, .idPc4);

	decodeStage decodeStage_inst (.clk, .reset, .idInstr, .idPc4, .wbWrite, .wbRegAddr,
		.wbWriteData, .stall, .redirectValid, .redirectTarget, .exRegWrite, .exMemToReg,
		.exMemRead, .exMemWrite, .exAluSrc, .exAluOp, .exRs, .exRt, .exDest, .exRsData,
		.exRtData, .exImm);

	executeStage executeStage_inst (.clk, .reset, .exRegWrite, .exMemToReg, .exMemRead,
		.exMemWrite, .exAluSrc, .exAluOp, .exRs, .exRt, .exDest, .exRsData, .exRtData,
		.exImm, .wbWrite, .wbRegAddr, .wbWriteData, .memRegWrite, .memMemToReg,
		.memMemRead, .memMemWrite, .memAluResult, .memStoreData, .memDest);

	memoryStage memoryStage_inst (.clk, .reset, .memRegWrite, .memMemToReg, .memMemRead,
		.memMemWrite, .memAluResult, .memStoreData, .memDest, .wbWrite, .wbRegAddr,
		.wbWriteData);

	// every register write shows up once here
	assign wbValid = wbWrite;
	assign wbReg = wbRegAddr;
	assign wbData = wbWriteData;

endmodule

//--- src/memoryStage.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module memoryStage (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       memRegWrite,
	input  logic                       memMemToReg,
	input  logic                       memMemRead,
	input  logic                       memMemWrite,
	input  logic [`DATA_WIDTH-1:0]     memAluResult,
	input  logic [`DATA_WIDTH-1:0]     memStoreData,
	input  logic [`REG_ADDR_WIDTH-1:0] memDest,
	output logic                       wbWrite,
	output logic [`REG_ADDR_WIDTH-1:0] wbRegAddr,
	output logic [`DATA_WIDTH-1:0]     wbWriteData
);
	localparam int dmemDepth = 1 << `DMEM_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0]     dmem [dmemDepth];
	logic [`DMEM_ADDR_WIDTH-1:0] dmemIndex;
	logic [`DATA_WIDTH-1:0]     loadData;
	logic                       wbMemToReg;
	logic [`DATA_WIDTH-1:0]     wbLoadData;
	logic [`DATA_WIDTH-1:0]     wbAluResult;

	// word index from the byte address
	assign dmemIndex = memAluResult[`DMEM_ADDR_WIDTH+1:2];
	assign loadData = memMemRead ? dmem[dmemIndex] : '0;

	// cleared on reset so each program starts from zeroed data
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < dmemDepth; i++)
				dmem[i] <= '0;
		end else if (memMemWrite) begin
			dmem[dmemIndex] <= memStoreData;
		end
	end

	//////////////////////////////
	// memory to write-back
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wbWrite <= 1'b0;
			wbMemToReg <= 1'b0;
			wbLoadData <= '0;
			wbAluResult <= '0;
			wbRegAddr <= '0;
		end else begin
			wbWrite <= memRegWrite;
			wbMemToReg <= memMemToReg;
			wbLoadData <= loadData;
			wbAluResult <= memAluResult;
			wbRegAddr <= memDest;
		end
	end

	assign wbWriteData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       exRegWrite,
	input  logic                       exMemToReg,
	input  logic                       exMemRead,
	input  logic                       exMemWrite,
	input  logic                       exAluSrc,
	input  aluOpT                      exAluOp,
	input  logic [`REG_ADDR_WIDTH-1:0] exRs,
	input  logic [`REG_ADDR_WIDTH-1:0] exRt,
	input  logic [`REG_ADDR_WIDTH-1:0] exDest,
	input  logic [`DATA_WIDTH-1:0]     exRsData,
	input  logic [`DATA_WIDTH-1:0]     exRtData,
	input  logic [`DATA_WIDTH-1:0]     exImm,
	input  logic                       wbWrite,
	input  logic [`REG_ADDR_WIDTH-1:0] wbRegAddr,
	input  logic [`DATA_WIDTH-1:0]     wbWriteData,
	output logic                       memRegWrite,
	output logic                       memMemToReg,
	output logic                       memMemRead,
	output logic                       memMemWrite,
	output logic [`DATA_WIDTH-1:0]     memAluResult,
	output logic [`DATA_WIDTH-1:0]     memStoreData,
	output logic [`REG_ADDR_WIDTH-1:0] memDest
);
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] fwdB;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluResult;

	// newest producer wins: memory stage, then write-back, then decode
	function automatic logic [`DATA_WIDTH-1:0] selectOperand(
		input logic [`REG_ADDR_WIDTH-1:0] addr,
		input logic [`DATA_WIDTH-1:0]     decoded
	);
		if (memRegWrite && memDest == addr)
			return memAluResult;
		if (wbWrite && wbRegAddr == addr)
			return wbWriteData;
		return decoded;
	endfunction

	always_comb begin
		opA = selectOperand(exRs, exRsData);
		fwdB = selectOperand(exRt, exRtData);
		opB = exAluSrc ? exImm : fwdB;
	end

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (exAluOp)
			aluAnd:  aluResult = opA & opB;
			aluOr:   aluResult = opA | opB;
			aluSub:  aluResult = opA - opB;
			aluSlt:  aluResult = ($signed(opA) < $signed(opB)) ? 1 : 0;
			default: aluResult = opA + opB;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			memRegWrite <= 1'b0;
			memMemToReg <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memAluResult <= '0;
			memStoreData <= '0;
			memDest <= '0;
		end else begin
			memRegWrite <= exRegWrite;
			memMemToReg <= exMemToReg;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
			memAluResult <= aluResult;
			// store data needs the forwarded rt too
			memStoreData <= fwdB;
			memDest <= exDest;
		end
	end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`DATA_WIDTH-1:0]     idInstr,
	input  logic [`DATA_WIDTH-1:0]     idPc4,
	input  logic                       wbWrite,
	input  logic [`REG_ADDR_WIDTH-1:0] wbRegAddr,
	input  logic [`DATA_WIDTH-1:0]     wbWriteData,
	output logic                       stall,
	output logic                       redirectValid,
	output logic [`DATA_WIDTH-1:0]     redirectTarget,
	output logic                       exRegWrite,
	output logic                       exMemToReg,
	output logic                       exMemRead,
	output logic                       exMemWrite,
	output logic                       exAluSrc,
	output aluOpT                      exAluOp,
	output logic [`REG_ADDR_WIDTH-1:0] exRs,
	output logic [`REG_ADDR_WIDTH-1:0] exRt,
	output logic [`REG_ADDR_WIDTH-1:0] exDest,
	output logic [`DATA_WIDTH-1:0]     exRsData,
	output logic [`DATA_WIDTH-1:0]     exRtData,
	output logic [`DATA_WIDTH-1:0]     exImm
);
	logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];
	opcodeT                     opcode;
	logic [`REG_ADDR_WIDTH-1:0] rs;
	logic [`REG_ADDR_WIDTH-1:0] rt;
	logic [`REG_ADDR_WIDTH-1:0] rd;
	logic [`REG_ADDR_WIDTH-1:0] dest;
	logic [5:0]                 funct;
	logic [`DATA_WIDTH-1:0]     imm;
	logic [`DATA_WIDTH-1:0]     rsData;
	logic [`DATA_WIDTH-1:0]     rtData;
	logic                       regWrite;
	logic                       memToReg;
	logic                       memRead;
	logic                       memWrite;
	logic                       aluSrc;
	logic                       isBeq;
	logic                       isJ;
	aluOpT                      aluOp;

	assign opcode = opcodeT'(idInstr[31:26]);
	assign rs = idInstr[25:21];
	assign rt = idInstr[20:16];
	assign rd = idInstr[15:11];
	assign funct = idInstr[5:0];
	assign imm = {{(`DATA_WIDTH-16){idInstr[15]}}, idInstr[15:0]};

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb begin
		regWrite = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		isBeq = 1'b0;
		isJ = 1'b0;
		aluOp = aluAdd;
		dest = rt;
		case (opcode)
			opRtype: begin
				regWrite = 1'b1;
				dest = rd;
				// 100000 and anything unknown fall back to add
				case (funct)
					6'b100010: aluOp = aluSub;
					6'b100100: aluOp = aluAnd;
					6'b100101: aluOp = aluOr;
					6'b101010: aluOp = aluSlt;
					default:   aluOp = aluAdd;
				endcase
			end
			opAddi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			opLw: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead = 1'b1;
				aluSrc = 1'b1;
			end
			opSw: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			opBeq: isBeq = 1'b1;
			opJ: isJ = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////
	// register file
	//////////////////////////////

	// r0 reads zero, a same-cycle write-back passes straight through
	function automatic logic [`DATA_WIDTH-1:0] readReg(input logic [`REG_ADDR_WIDTH-1:0] addr);
		if (addr == '0)
			return '0;
		if (wbWrite && wbRegAddr == addr)
			return wbWriteData;
		return regs[addr];
	endfunction

	always_comb begin
		rsData = readReg(rs);
		rtData = readReg(rt);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbWrite && wbRegAddr != '0) begin
			regs[wbRegAddr] <= wbWriteData;
		end
	end

	// load in execute feeding this instruction, j reads no registers
	assign stall = exMemRead && !isJ && (exRt == rs || exRt == rt);

	// beq compares unforwarded register values
	assign redirectValid = isJ || (isBeq && !stall && rsData == rtData);
	assign redirectTarget = isJ
		? {idPc4[`DATA_WIDTH-1:`DATA_WIDTH-4], idInstr[25:0], 2'b00}
		: idPc4 + {imm[`DATA_WIDTH-3:0], 2'b00};

	//////////////////////////////
	// decode to execute register
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exAluSrc <= 1'b0;
			exAluOp <= aluAdd;
			exRs <= '0;
			exRt <= '0;
			exDest <= '0;
			exRsData <= '0;
			exRtData <= '0;
			exImm <= '0;
		end else begin
			// a stall turns the slot into a bubble
			exRegWrite <= regWrite && !stall && dest != '0;
			exMemToReg <= memToReg && !stall;
			exMemRead <= memRead && !stall;
			exMemWrite <= memWrite && !stall;
			exAluSrc <= aluSrc;
			exAluOp <= aluOp;
			exRs <= rs;
			exRt <= rt;
			exDest <= dest;
			exRsData <= rsData;
			exRtData <= rtData;
			exImm <= imm;
		end
	end

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetchStage import cpuPkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        loadValid,
	input  logic [`IMEM_ADDR_WIDTH-1:0] loadAddr,
	input  logic [`DATA_WIDTH-1:0]      loadWord,
	input  logic                        start,
	input  logic                        stall,
	input  logic                        redirectValid,
	input  logic [`DATA_WIDTH-1:0]      redirectTarget,
	output logic [`DATA_WIDTH-1:0]      idInstr,
	output logic [`DATA_WIDTH-1:0]      idPc4
);
	localparam int imemDepth = 1 << `IMEM_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] imem [imemDepth];
	fetchStateT             state;
	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] pc4;
	logic [`DATA_WIDTH-1:0] fetchedWord;

	// byte address, low two bits dropped
	assign pc4 = pc + 4;
	assign fetchedWord = imem[pc[`IMEM_ADDR_WIDTH+1:2]];

	// program load port, only while idle
	always_ff @(posedge clk) begin
		if (loadValid && state == fetchIdle)
			imem[loadAddr] <= loadWord;
	end

	//////////////////////////////
	// pc and decode register
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fetchIdle;
			pc <= '0;
			idInstr <= '0;
			idPc4 <= '0;
		end else if (state == fetchIdle) begin
			// nothing but bubbles until start
			idInstr <= '0;
			idPc4 <= '0;
			if (start) begin
				state <= fetchRunning;
				pc <= '0;
			end
		end else if (!stall) begin
			if (redirectValid) begin
				// squash the wrong-path word, no delay slot
				pc <= redirectTarget;
				idInstr <= '0;
			end else begin
				pc <= pc4;
				idInstr <= fetchedWord;
				idPc4 <= pc4;
			end
		end
	end

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

	//////////////////////////////
	// instruction opcodes
	//////////////////////////////

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		opRtype = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opAddi  = 6'b001000,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeT;

	// operations the execute stage ALU knows
	typedef enum logic [2:0] {
		aluAnd = 3'd0,
		aluOr  = 3'd1,
		aluAdd = 3'd2,
		aluSub = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	//////////////////////////////
	// fetch control
	//////////////////////////////

	// idle while a program is loaded, running after start
	typedef enum logic {
		fetchIdle    = 1'b0,
		fetchRunning = 1'b1
	} fetchStateT;

endpackage

//--- src/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////

// word width of registers, ALU and memories
`define DATA_WIDTH 32

// register index as found in the rs, rt and rd fields
`define REG_ADDR_WIDTH 5

// architectural register count
`define REG_COUNT 32

//////////////////////////////
// memory sizes
//////////////////////////////

// instruction memory word index, 64 words
`define IMEM_ADDR_WIDTH 6

// data memory word index, 32 words
`define DMEM_ADDR_WIDTH 5

`endif
